//--- logic/bus_pkg.sv
package bus_pkg;

	// bus widths
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;
	localparam int STRB_W   = DATA_W / 8;
	localparam int REGION_W = 4; // top address nibble picks the region
	localparam int IDX_W    = 3; // word index, address bits 4:2

	// region map, 0x1000_0000 apart
	localparam logic [ADDR_W-1:0] REG_BANK_BASE = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] DDS_BASE      = 32'h1000_0000;

	// dds register file
	localparam logic [IDX_W-1:0] DDS_FREQ_IDX  = 3'd0;
	localparam logic [IDX_W-1:0] DDS_PHASE_IDX = 3'd1;
	localparam logic [IDX_W-1:0] DDS_CTRL_IDX  = 3'd2; // bit 0 enables the accumulator

	localparam int WAVE_W = 8;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11; // nothing mapped at that region

endpackage

//--- logic/bus_router.sv
module bus_router (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       wr_valid,
	output logic                       wr_ready,
	input  logic [bus_pkg::ADDR_W-1:0] wr_addr,
	input  logic [bus_pkg::DATA_W-1:0] wr_data,
	input  logic [bus_pkg::STRB_W-1:0] wr_strb,

	input  logic                       rd_valid,
	output logic                       rd_ready,
	input  logic [bus_pkg::ADDR_W-1:0] rd_addr,

	input  logic                       txn_done,
	output logic                       dec_err,
	output logic                       dec_err_write,

	bus_slot_if.router                 reg_slot,
	bus_slot_if.router                 dds_slot
);

	logic busy;
	logic issue; // high the cycle after acceptance
	logic accept_wr;
	logic accept_rd;
	logic [bus_pkg::ADDR_W-1:0]   req_addr;
	logic [bus_pkg::REGION_W-1:0] region_q;
	logic                         req_write;
	logic [bus_pkg::IDX_W-1:0]    req_idx;
	logic [bus_pkg::DATA_W-1:0]   req_wdata;
	logic [bus_pkg::STRB_W-1:0]   req_strb;
	logic reg_hit;
	logic dds_hit;

	assign wr_ready  = !busy;
	assign rd_ready  = !busy && !wr_valid; // write wins a tie
	assign accept_wr = wr_valid && wr_ready;
	assign accept_rd = rd_valid && rd_ready;
	assign req_addr  = accept_wr ? wr_addr : rd_addr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			issue <= 1'b0;
		end else begin
			issue <= accept_wr || accept_rd;
			if (accept_wr || accept_rd)
				busy <= 1'b1;
			else if (txn_done)
				busy <= 1'b0;
		end
	end

	// request payload, only meaningful alongside issue
	always_ff @(posedge clk) begin
		if (accept_wr || accept_rd) begin
			region_q  <= req_addr[bus_pkg::ADDR_W-1 -: bus_pkg::REGION_W];
			req_idx   <= req_addr[bus_pkg::IDX_W+1:2];
			req_write <= accept_wr;
			req_wdata <= wr_data;
			req_strb  <= accept_wr ? wr_strb : '0;
		end
	end

	// region compare against the base table
	assign reg_hit = {region_q, {(bus_pkg::ADDR_W - bus_pkg::REGION_W){1'b0}}}
		== bus_pkg::REG_BANK_BASE;
	assign dds_hit = {region_q, {(bus_pkg::ADDR_W - bus_pkg::REGION_W){1'b0}}}
		== bus_pkg::DDS_BASE;

	assign reg_slot.req_valid = issue && reg_hit;
	assign reg_slot.req_write = req_write;
	assign reg_slot.req_idx   = req_idx;
	assign reg_slot.req_wdata = req_wdata;
	assign reg_slot.req_strb  = req_strb;

	assign dds_slot.req_valid = issue && dds_hit;
	assign dds_slot.req_write = req_write;
	assign dds_slot.req_idx   = req_idx;
	assign dds_slot.req_wdata = req_wdata;
	assign dds_slot.req_strb  = req_strb;

	// unmapped regions go straight to the merger
	assign dec_err       = issue && !reg_hit && !dds_hit;
	assign dec_err_write = req_write;

endmodule

//--- logic/bus_slot_if.sv
interface bus_slot_if;

	// request side, one-cycle strobe
	logic                       req_valid;
	logic                       req_write;
	logic [bus_pkg::IDX_W-1:0]  req_idx;
	logic [bus_pkg::DATA_W-1:0] req_wdata;
	logic [bus_pkg::STRB_W-1:0] req_strb;

	// response side, also a strobe
	logic                       resp_valid;
	logic [bus_pkg::DATA_W-1:0] resp_rdata;
	bus_pkg::resp_t             resp_code;

	modport router (
		output req_valid,
		output req_write,
		output req_idx,
		output req_wdata,
		output req_strb
	);

	modport slave (
		input  req_valid,
		input  req_write,
		input  req_idx,
		input  req_wdata,
		input  req_strb,
		output resp_valid,
		output resp_rdata,
		output resp_code
	);

	// merger needs the request direction too
	modport merge (
		input req_valid,
		input req_write,
		input resp_valid,
		input resp_rdata,
		input resp_code
	);

endinterface

//--- logic/bus_top.sv
module bus_top (
	input  logic                       clk,
	input  logic                       rst_n,

	// write request
	input  logic                       wr_valid,
	output logic                       wr_ready,
	input  logic [bus_pkg::ADDR_W-1:0] wr_addr,
	input  logic [bus_pkg::DATA_W-1:0] wr_data,
	input  logic [bus_pkg::STRB_W-1:0] wr_strb,

	// write response
	output logic                       b_valid,
	input  logic                       b_ready,
	output bus_pkg::resp_t             b_resp,

	// read request
	input  logic                       rd_valid,
	output logic                       rd_ready,
	input  logic [bus_pkg::ADDR_W-1:0] rd_addr,

	// read response
	output logic                       r_valid,
	input  logic                       r_ready,
	output logic [bus_pkg::DATA_W-1:0] r_data,
	output bus_pkg::resp_t             r_resp,

	output logic [bus_pkg::WAVE_W-1:0] da_data
);

	logic dec_err;
	logic dec_err_write;
	logic txn_done;

	bus_slot_if reg_slot ();
	bus_slot_if dds_slot ();

	bus_router bus_router_inst (
		.clk           (clk          ),
		.rst_n         (rst_n        ),
		.wr_valid      (wr_valid     ),
		.wr_ready      (wr_ready     ),
		.wr_addr       (wr_addr      ),
		.wr_data       (wr_data      ),
		.wr_strb       (wr_strb      ),
		.rd_valid      (rd_valid     ),
		.rd_ready      (rd_ready     ),
		.rd_addr       (rd_addr      ),
		.txn_done      (txn_done     ),
		.dec_err       (dec_err      ),
		.dec_err_write (dec_err_write),
		.reg_slot      (reg_slot     ),
		.dds_slot      (dds_slot     )
	);

	reg_bank_slave reg_bank_slave_inst (
		.clk   (clk     ),
		.rst_n (rst_n   ),
		.slot  (reg_slot)
	);

	// region 1, wave out to the dac pins
	dds_slave dds_slave_inst (
		.clk   (clk     ),
		.rst_n (rst_n   ),
		.wave  (da_data ),
		.slot  (dds_slot)
	);

	resp_merge resp_merge_inst (
		.clk           (clk          ),
		.rst_n         (rst_n        ),
		.dec_err       (dec_err      ),
		.dec_err_write (dec_err_write),
		.reg_slot      (reg_slot     ),
		.dds_slot      (dds_slot     ),
		.b_valid       (b_valid      ),
		.b_ready       (b_ready      ),
		.b_resp        (b_resp       ),
		.r_valid       (r_valid      ),
		.r_ready       (r_ready      ),
		.r_data        (r_data       ),
		.r_resp        (r_resp       ),
		.txn_done      (txn_done     )
	);

endmodule

//--- logic/dds_slave.sv
module dds_slave (
	input  logic                       clk,
	input  logic                       rst_n,
	output logic [bus_pkg::WAVE_W-1:0] wave,
	bus_slot_if.slave                  slot
);

	logic [bus_pkg::DATA_W-1:0] freq_word;
	logic [bus_pkg::DATA_W-1:0] phase_off;
	logic                       enable;
	logic [bus_pkg::DATA_W-1:0] phase_acc;
	logic [bus_pkg::DATA_W-1:0] phase_sum;
	logic                       idx_ok;
	logic [bus_pkg::DATA_W-1:0] rd_word;

	assign idx_ok = (slot.req_idx == bus_pkg::DDS_FREQ_IDX) ||
		(slot.req_idx == bus_pkg::DDS_PHASE_IDX) ||
		(slot.req_idx == bus_pkg::DDS_CTRL_IDX);

	always_comb begin
		rd_word = '0;
		case (slot.req_idx)
			bus_pkg::DDS_FREQ_IDX:  rd_word = freq_word;
			bus_pkg::DDS_PHASE_IDX: rd_word = phase_off;
			bus_pkg::DDS_CTRL_IDX:  rd_word = {{(bus_pkg::DATA_W-1){1'b0}}, enable};
			default:                rd_word = '0;
		endcase
	end

	// whole word writes, strobes not used here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			freq_word <= '0;
			phase_off <= '0;
			enable    <= 1'b0;
		end else if (slot.req_valid && slot.req_write) begin
			case (slot.req_idx)
				bus_pkg::DDS_FREQ_IDX:  freq_word <= slot.req_wdata;
				bus_pkg::DDS_PHASE_IDX: phase_off <= slot.req_wdata;
				bus_pkg::DDS_CTRL_IDX:  enable    <= slot.req_wdata[0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			slot.resp_valid <= 1'b0;
		else
			slot.resp_valid <= slot.req_valid;
	end

	always_ff @(posedge clk) begin
		if (slot.req_valid) begin
			slot.resp_rdata <= slot.req_write ? '0 : rd_word;
			slot.resp_code  <= idx_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
		end
	end

	// sawtooth from the accumulator top bits
	assign phase_sum = phase_acc + phase_off;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase_acc <= '0;
			wave      <= '0;
		end else begin
			if (enable)
				phase_acc <= phase_acc + freq_word;
			wave <= phase_sum[bus_pkg::DATA_W-1 -: bus_pkg::WAVE_W];
		end
	end

endmodule

//--- logic/reg_bank_slave.sv
module reg_bank_slave (
	input  logic      clk,
	input  logic      rst_n,
	bus_slot_if.slave slot
);

	localparam int NUM_REGS = 2 ** bus_pkg::IDX_W;

	logic [bus_pkg::DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (slot.req_valid && slot.req_write) begin
			for (int b = 0; b < bus_pkg::STRB_W; b++) begin
				if (slot.req_strb[b])
					regs[slot.req_idx][b*8 +: 8] <= slot.req_wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			slot.resp_valid <= 1'b0;
		else
			slot.resp_valid <= slot.req_valid; // always one cycle later
	end

	// read data and code
	always_ff @(posedge clk) begin
		if (slot.req_valid) begin
			slot.resp_rdata <= slot.req_write ? '0 : regs[slot.req_idx];
			slot.resp_code  <= bus_pkg::RESP_OKAY;
		end
	end

endmodule

//--- logic/resp_merge.sv
module resp_merge (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       dec_err,
	input  logic                       dec_err_write,
	bus_slot_if.merge                  reg_slot,
	bus_slot_if.merge                  dds_slot,

	output logic                       b_valid,
	input  logic                       b_ready,
	output bus_pkg::resp_t             b_resp,

	output logic                       r_valid,
	input  logic                       r_ready,
	output logic [bus_pkg::DATA_W-1:0] r_data,
	output bus_pkg::resp_t             r_resp,

	output logic                       txn_done
);

	logic                       dir_write; // direction of the slot request in flight
	logic                       slot_resp;
	logic [bus_pkg::DATA_W-1:0] slot_rdata;
	bus_pkg::resp_t             slot_code;

	always_ff @(posedge clk) begin
		if (!rst_n)
			dir_write <= 1'b0;
		else if (reg_slot.req_valid)
			dir_write <= reg_slot.req_write;
		else if (dds_slot.req_valid)
			dir_write <= dds_slot.req_write;
	end

	// only one slot answers per transaction
	assign slot_resp  = reg_slot.resp_valid || dds_slot.resp_valid;
	assign slot_rdata = reg_slot.resp_valid ? reg_slot.resp_rdata : dds_slot.resp_rdata;
	assign slot_code  = reg_slot.resp_valid ? reg_slot.resp_code : dds_slot.resp_code;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			b_valid  <= 1'b0;
			r_valid  <= 1'b0;
			txn_done <= 1'b0;
		end else begin
			txn_done <= 1'b0;
			if (slot_resp) begin
				b_valid <= dir_write;
				r_valid <= !dir_write;
			end else if (dec_err) begin
				b_valid <= dec_err_write;
				r_valid <= !dec_err_write;
			end else if (b_valid && b_ready) begin
				b_valid  <= 1'b0;
				txn_done <= 1'b1;
			end else if (r_valid && r_ready) begin
				r_valid  <= 1'b0;
				txn_done <= 1'b1;
			end
		end
	end

	// response payload held until taken
	always_ff @(posedge clk) begin
		if (slot_resp) begin
			b_resp <= slot_code;
			r_resp <= slot_code;
			r_data <= dir_write ? '0 : slot_rdata;
		end else if (dec_err) begin
			b_resp <= bus_pkg::RESP_DECERR;
			r_resp <= bus_pkg::RESP_DECERR;
			r_data <= '0;
		end
	end

endmodule

//--- tb.f
logic/bus_pkg.sv
logic/bus_slot_if.sv
logic/bus_router.sv
logic/reg_bank_slave.sv
logic/dds_slave.sv
logic/resp_merge.sv
logic/bus_top.sv
test/tb_clock_gen.sv
test/tb_bus_top.sv

//--- test/tb_bus_top.sv
module tb_bus_top;

	timeunit 1ns;
	timeprecision 100ps;

	logic                       clk;
	logic                       rst_n;
	logic                       wr_valid;
	logic                       wr_ready;
	logic [bus_pkg::ADDR_W-1:0] wr_addr;
	logic [bus_pkg::DATA_W-1:0] wr_data;
	logic [bus_pkg::STRB_W-1:0] wr_strb;
	logic                       b_valid;
	logic                       b_ready;
	bus_pkg::resp_t             b_resp;
	logic                       rd_valid;
	logic                       rd_ready;
	logic [bus_pkg::ADDR_W-1:0] rd_addr;
	logic                       r_valid;
	logic                       r_ready;
	logic [bus_pkg::DATA_W-1:0] r_data;
	bus_pkg::resp_t             r_resp;
	logic [bus_pkg::WAVE_W-1:0] da_data;

	integer seed = 32'he5ca049a;
	int txn_count = 0; // transactions issued so far
	int wd_cycles = 0;
	logic [bus_pkg::DATA_W-1:0] bank_model [8];

	tb_clock_gen tb_clock_gen_inst (
		.clk   (clk  ),
		.rst_n (rst_n)
	);

	bus_top bus_top_inst (
		.clk      (clk     ),
		.rst_n    (rst_n   ),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr_addr  (wr_addr ),
		.wr_data  (wr_data ),
		.wr_strb  (wr_strb ),
		.b_valid  (b_valid ),
		.b_ready  (b_ready ),
		.b_resp   (b_resp  ),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready),
		.rd_addr  (rd_addr ),
		.r_valid  (r_valid ),
		.r_ready  (r_ready ),
		.r_data   (r_data  ),
		.r_resp   (r_resp  ),
		.da_data  (da_data )
	);

	task automatic check_resp(input string name, input bus_pkg::resp_t exp,
		input bus_pkg::resp_t act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "response code mismatch");
		end
	endtask

	task automatic check_data(input string name, input logic [bus_pkg::DATA_W-1:0] exp,
		input logic [bus_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_wave(input string name, input logic [bus_pkg::WAVE_W-1:0] exp,
		input logic [bus_pkg::WAVE_W-1:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "wave sample mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "handshake flag mismatch");
		end
	endtask

	function automatic logic [bus_pkg::ADDR_W-1:0] slot_addr(
		input logic [bus_pkg::ADDR_W-1:0] base, input int idx);
		return base + (idx * 4); // word index in bits 4:2
	endfunction

	function automatic logic [bus_pkg::DATA_W-1:0] merge_bytes(
		input logic [bus_pkg::DATA_W-1:0] old_word, input logic [bus_pkg::DATA_W-1:0] new_word,
		input logic [bus_pkg::STRB_W-1:0] strb);
		logic [bus_pkg::DATA_W-1:0] word;
		word = old_word;
		for (int b = 0; b < bus_pkg::STRB_W; b++) begin
			if (strb[b])
				word[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return word;
	endfunction

	// returns once the request transfer edge has passed
	task automatic send_write(input logic [bus_pkg::ADDR_W-1:0] addr,
		input logic [bus_pkg::DATA_W-1:0] data, input logic [bus_pkg::STRB_W-1:0] strb);
		@(posedge clk);
		#1;
		wr_valid = 1'b1;
		wr_addr  = addr;
		wr_data  = data;
		wr_strb  = strb;
		txn_count++;
		@(negedge clk);
		while (!wr_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		wr_valid = 1'b0;
	endtask

	task automatic send_read(input logic [bus_pkg::ADDR_W-1:0] addr);
		@(posedge clk);
		#1;
		rd_valid = 1'b1;
		rd_addr  = addr;
		txn_count++;
		@(negedge clk);
		while (!rd_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		rd_valid = 1'b0;
	endtask

	task automatic do_write(input logic [bus_pkg::ADDR_W-1:0] addr,
		input logic [bus_pkg::DATA_W-1:0] data, input logic [bus_pkg::STRB_W-1:0] strb,
		output bus_pkg::resp_t resp);
		send_write(addr, data, strb);
		@(negedge clk);
		while (!b_valid)
			@(negedge clk);
		resp = b_resp; // taken on the next edge since b_ready is high
	endtask

	task automatic do_read(input logic [bus_pkg::ADDR_W-1:0] addr,
		output logic [bus_pkg::DATA_W-1:0] data, output bus_pkg::resp_t resp);
		send_read(addr);
		@(negedge clk);
		while (!r_valid)
			@(negedge clk);
		data = r_data;
		resp = r_resp;
	endtask

	task automatic write_and_check(input logic [bus_pkg::ADDR_W-1:0] addr,
		input logic [bus_pkg::DATA_W-1:0] data, input logic [bus_pkg::STRB_W-1:0] strb,
		input bus_pkg::resp_t exp_resp);
		bus_pkg::resp_t resp;
		do_write(addr, data, strb, resp);
		check_resp("b_resp", exp_resp, resp);
	endtask

	task automatic read_and_check(input logic [bus_pkg::ADDR_W-1:0] addr,
		input logic [bus_pkg::DATA_W-1:0] exp_data, input bus_pkg::resp_t exp_resp);
		logic [bus_pkg::DATA_W-1:0] data;
		bus_pkg::resp_t resp;
		do_read(addr, data, resp);
		check_resp("r_resp", exp_resp, resp);
		check_data("r_data", exp_data, data);
	endtask

	task automatic reset_state_test();
		check_flag("wr_ready", 1'b1, wr_ready);
		check_flag("rd_ready", 1'b1, rd_ready);
		check_flag("b_valid", 1'b0, b_valid);
		check_flag("r_valid", 1'b0, r_valid);
		check_wave("da_data", '0, da_data);
	endtask

	task automatic bank_rw_test();
		for (int i = 0; i < 8; i++) begin
			bank_model[i] = $random(seed);
			write_and_check(slot_addr(bus_pkg::REG_BANK_BASE, i), bank_model[i], 4'hf,
				bus_pkg::RESP_OKAY);
		end
		for (int i = 0; i < 8; i++)
			read_and_check(slot_addr(bus_pkg::REG_BANK_BASE, i), bank_model[i], bus_pkg::RESP_OKAY);
	endtask

	task automatic partial_strobe_test();
		logic [bus_pkg::DATA_W-1:0] wdata;
		logic [bus_pkg::STRB_W-1:0] strobes [3];
		strobes = '{4'b0101, 4'b1000, 4'b0110};
		for (int i = 0; i < 3; i++) begin
			wdata = $random(seed);
			write_and_check(slot_addr(bus_pkg::REG_BANK_BASE, i * 3), wdata, strobes[i],
				bus_pkg::RESP_OKAY);
			bank_model[i * 3] = merge_bytes(bank_model[i * 3], wdata, strobes[i]);
			read_and_check(slot_addr(bus_pkg::REG_BANK_BASE, i * 3), bank_model[i * 3],
				bus_pkg::RESP_OKAY);
		end
	endtask

	task automatic unmapped_test();
		logic [bus_pkg::REGION_W-1:0] regions [3];
		logic [bus_pkg::ADDR_W-1:0] rnd;
		logic [bus_pkg::ADDR_W-1:0] addr;
		regions = '{4'd2, 4'd7, 4'd15};
		for (int i = 0; i < 3; i++) begin
			rnd  = $random(seed);
			addr = {regions[i], rnd[bus_pkg::ADDR_W-bus_pkg::REGION_W-1:0]};
			write_and_check(addr, $random(seed), 4'hf, bus_pkg::RESP_DECERR);
			read_and_check(addr, '0, bus_pkg::RESP_DECERR);
		end
		write_and_check(slot_addr(bus_pkg::DDS_BASE, 5), $random(seed), 4'hf,
			bus_pkg::RESP_SLVERR);
		read_and_check(slot_addr(bus_pkg::DDS_BASE, 5), '0, bus_pkg::RESP_SLVERR);
		for (int i = 0; i < 8; i++)
			read_and_check(slot_addr(bus_pkg::REG_BANK_BASE, i), bank_model[i], bus_pkg::RESP_OKAY);
	endtask

	task automatic dds_test();
		logic [bus_pkg::DATA_W-1:0] freq;
		logic [bus_pkg::DATA_W-1:0] phase;
		logic [bus_pkg::WAVE_W-1:0] prev;
		logic [bus_pkg::WAVE_W-1:0] exp_wave;
		freq  = $random(seed);
		phase = $random(seed);
		write_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_FREQ_IDX), freq, 4'hf,
			bus_pkg::RESP_OKAY);
		read_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_FREQ_IDX), freq,
			bus_pkg::RESP_OKAY);
		write_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_PHASE_IDX), phase, 4'hf,
			bus_pkg::RESP_OKAY);
		read_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_PHASE_IDX), phase,
			bus_pkg::RESP_OKAY);
		read_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_CTRL_IDX), '0, bus_pkg::RESP_OKAY);

		// accumulator never ran so wave is the offset's top byte
		exp_wave = phase[bus_pkg::DATA_W-1 -: bus_pkg::WAVE_W];
		repeat (20) begin
			@(negedge clk);
			check_wave("da_data", exp_wave, da_data);
		end

		write_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_FREQ_IDX), 32'h0100_0000,
			4'hf, bus_pkg::RESP_OKAY);
		write_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_CTRL_IDX), 32'h1, 4'hf,
			bus_pkg::RESP_OKAY);
		read_and_check(slot_addr(bus_pkg::DDS_BASE, bus_pkg::DDS_CTRL_IDX), 32'h1,
			bus_pkg::RESP_OKAY);
		@(negedge clk);
		prev = da_data;
		repeat (20) begin
			@(negedge clk);
			exp_wave = prev + 1'b1; // one step of the top byte per cycle
			check_wave("da_data", exp_wave, da_data);
			prev = da_data;
		end
	endtask

	task automatic backpressure_test();
		logic [bus_pkg::DATA_W-1:0] wdata;
		wdata = $random(seed);
		@(posedge clk);
		#1;
		b_ready = 1'b0;
		send_write(slot_addr(bus_pkg::REG_BANK_BASE, 5), wdata, 4'hf);
		@(negedge clk);
		while (!b_valid)
			@(negedge clk);
		repeat (6) begin
			check_flag("b_valid", 1'b1, b_valid);
			check_resp("b_resp", bus_pkg::RESP_OKAY, b_resp);
			check_flag("wr_ready", 1'b0, wr_ready);
			check_flag("rd_ready", 1'b0, rd_ready);
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		b_ready = 1'b1;
		@(negedge clk);
		check_flag("b_valid", 1'b1, b_valid);
		@(negedge clk);
		check_flag("b_valid", 1'b0, b_valid);
		while (!wr_ready)
			@(negedge clk);
		bank_model[5] = wdata;
		read_and_check(slot_addr(bus_pkg::REG_BANK_BASE, 5), bank_model[5], bus_pkg::RESP_OKAY);
	endtask

	// limit grows with each issued transaction
	initial begin
		while (wd_cycles <= 200 * txn_count + 2000) begin
			@(posedge clk);
			wd_cycles++;
		end
		$display("timeout: the bus stopped responding after %0d cycles", wd_cycles);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		wr_valid = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		wr_strb  = '0;
		b_ready  = 1'b1;
		rd_valid = 1'b0;
		rd_addr  = '0;
		r_ready  = 1'b1;
		@(negedge clk);
		while (!rst_n)
			@(negedge clk);
		reset_state_test();
		bank_rw_test();
		partial_strobe_test();
		unmapped_test();
		dds_test();
		backpressure_test();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// reset held over two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule
